/* all.f */
logic/soc_map_pkg.sv
logic/mem_bus_pkg.sv
logic/addr_decoder.sv
logic/mem_bank.sv
logic/rsp_merger.sv
logic/debug_holdoff.sv
logic/harness_top.sv
testbench/tb_harness.sv

/* testbench/tests_mem.txt */
# columns: name op addr wdata be exp_rdata exp_err, all numbers in hex
# D records: addr = debug_req_i, wdata = debug_en_i, exp_rdata = expected debug_req_o
dbg_00     D 00000000 00000000 0 00000000 0
dbg_01     D 00000000 00000001 0 00000000 0
dbg_10     D 00000001 00000000 0 00000000 0
dbg_11     D 00000001 00000001 0 00000001 0
b0_first_w W 00001000 10000001 f 00000000 0
b0_last_w  W 000013fc 100003fc f 00000000 0
b0_mid_w   W 00001200 10000200 f 00000000 0
b1_first_w W 00002000 20000001 f 00000000 0
b1_last_w  W 000023fc 200003fc f 00000000 0
b1_mid_w   W 00002200 20000200 f 00000000 0
b2_first_w W 00003000 30000001 f 00000000 0
b2_last_w  W 000033fc 300003fc f 00000000 0
b2_mid_w   W 00003200 30000200 f 00000000 0
b3_first_w W 00004000 40000001 f 00000000 0
b3_last_w  W 000043fc 400003fc f 00000000 0
b3_mid_w   W 00004200 40000200 f 00000000 0
b0_first_r R 00001000 00000000 0 10000001 0
b0_last_r  R 000013fc 00000000 0 100003fc 0
b0_mid_r   R 00001200 00000000 0 10000200 0
b1_first_r R 00002000 00000000 0 20000001 0
b1_last_r  R 000023fc 00000000 0 200003fc 0
b1_mid_r   R 00002200 00000000 0 20000200 0
b2_first_r R 00003000 00000000 0 30000001 0
b2_last_r  R 000033fc 00000000 0 300003fc 0
b2_mid_r   R 00003200 00000000 0 30000200 0
b3_first_r R 00004000 00000000 0 40000001 0
b3_last_r  R 000043fc 00000000 0 400003fc 0
b3_mid_r   R 00004200 00000000 0 40000200 0
part_full  W 00002040 aabbccdd f 00000000 0
part_lo_w  W 00002040 11223344 3 00000000 0
part_lo_r  R 00002040 00000000 0 aabb3344 0
part_odd_w W 00002040 55667788 a 00000000 0
part_odd_r R 00002040 00000000 0 55bb7744 0
gap_w      W 00001400 deadbeef f 00000000 1
gap_r      R 00001400 00000000 0 00000000 1
low_r      R 00000ffc 00000000 0 00000000 1
top_w      W 00004400 cafef00d f 00000000 1
high_r     R 80000000 00000000 0 00000000 1

/* testbench/tb_harness.sv */
// testbench for the memory harness, replays the test records, then a burst and a full readback
`default_nettype none
`timescale 1ns/10ps

module tb_harness;

  import soc_map_pkg::*;
  import mem_bus_pkg::*;

  localparam int          MaxRecords    = 64;
  localparam int          BurstLen      = 16;
  localparam int          TimeoutMargin = 100;
  localparam logic [31:0] LfsrSeed      = 32'h6f10;
  localparam              TestFile      = "testbench/tests_mem.txt";

  logic     clk_i;
  logic     rst_ni;
  mem_req_t req;
  mem_rsp_t rsp;
  logic     debug_req;
  logic     debug_en;
  logic     debug_req_o;

  // --------------------
  // records and model
  // --------------------
  logic [127:0] rec_name  [MaxRecords];
  logic [7:0]   rec_op    [MaxRecords];
  logic [31:0]  rec_addr  [MaxRecords];
  logic [31:0]  rec_wdata [MaxRecords];
  logic [3:0]   rec_be    [MaxRecords];
  logic [31:0]  rec_rdata [MaxRecords];
  logic         rec_err   [MaxRecords];
  logic [31:0]  burst_addr [BurstLen];
  data_t        ref_mem [NumBanks*BankWords];
  logic [31:0]  lfsr_q;
  int           num_records;
  int           errors;
  int           cycles;
  int           cycle_limit;

  harness_top uut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_i       ( req         ),
    .rsp_o       ( rsp         ),
    .debug_req_i ( debug_req   ),
    .debug_en_i  ( debug_en    ),
    .debug_req_o ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  // watchdog, limit set once the records are loaded
  initial begin
    cycles = 0;
    while (cycle_limit == 0 || cycles <= cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Finished with errors");
    $finish;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic lfsr_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // region i spans BankBytes from BankBase + i * BankStride
  function automatic bit map_addr(input logic [31:0] addr, output int flat);
    logic [31:0] lo;
    map_addr = 1'b0;
    flat     = 0;
    for (int i = 0; i < NumBanks; i++) begin
      lo = BankBase + i * BankStride;
      if (addr >= lo && addr - lo < BankBytes) begin
        map_addr = 1'b1;
        flat     = i * BankWords + (addr - lo) / 4;
      end
    end
  endfunction

  task automatic model_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int flat;
    err   = !map_addr(addr, flat);
    rdata = '0;
    if (!err) begin
      for (int b = 0; b < 4; b++) begin
        if (we && be[b]) begin
          ref_mem[flat][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      rdata = ref_mem[flat];
    end
  endtask

  // --------------------
  // bus access
  // --------------------

  // drive one request, its response is due on the next edge
  task automatic issue(input logic [127:0] name, input logic we, input logic [31:0] addr,
                       input logic [3:0] be, input logic [31:0] wdata,
                       input logic [31:0] exp_rdata, input logic exp_err);
    req = '{req: 1'b1, we: we, addr: addr, be: be, wdata: wdata};
    @(posedge clk_i);
    #1;
    req.req = 1'b0;
    assert (rsp.valid) else begin
      errors++;
      $display("%0s: no response one cycle after the request", name);
    end
    assert (rsp.err == exp_err) else begin
      errors++;
      $display("[FAIL] %0s err expected %0b actual %0b", name, exp_err, rsp.err);
    end
    if (!we || exp_err) begin
      assert (rsp.rdata == exp_rdata) else begin
        errors++;
        $display("[FAIL] %0s rdata expected %h actual %h", name, exp_rdata, rsp.rdata);
      end
    end
  endtask

  task automatic idle_cycle();
    req = '0;
    @(posedge clk_i);
    #1;
    assert (!rsp.valid) else begin
      errors++;
      $display("response valid without a request in the previous cycle");
    end
  endtask

  initial begin
    int          fd;
    int          cnt;
    int          n_edges;
    logic [1023:0] line;
    logic [31:0] m_rdata;
    logic        m_err;
    logic [31:0] rnd;
    logic [31:0] addr;
    req         = '0;
    debug_req   = 1'b1;
    debug_en    = 1'b1;
    rst_ni      = 1'b0;
    errors      = 0;
    num_records = 0;
    lfsr_q      = LfsrSeed;
    for (int w = 0; w < NumBanks*BankWords; w++) begin
      ref_mem[w] = '0;
    end
    fd = $fopen(TestFile, "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the test file %0s", TestFile);
    end else begin
      while (!$feof(fd) && num_records < MaxRecords) begin
        line = '0;
        cnt  = $fgets(line, fd);
        cnt  = $sscanf(line, "%s %c %h %h %h %h %h", rec_name[num_records],
                       rec_op[num_records], rec_addr[num_records], rec_wdata[num_records],
                       rec_be[num_records], rec_rdata[num_records], rec_err[num_records]);
        if (cnt == 7 && rec_name[num_records] != "#") begin
          num_records++;
        end
      end
      $fclose(fd);
    end
    cycle_limit = DebugHoldoffCycles + 4 * (num_records + 2 * BurstLen + NumBanks * BankWords)
                  + TimeoutMargin;

    // --------------------
    // reset and hold-off
    // --------------------
    repeat (10) @(posedge clk_i);
    #1;
    assert (!debug_req_o && !rsp.valid) else begin
      errors++;
      $display("debug request or response active during reset");
    end
    rst_ni  = 1'b1;
    n_edges = 0;
    while (!debug_req_o && n_edges <= DebugHoldoffCycles) begin
      @(posedge clk_i);
      #1;
      n_edges++;
    end
    assert (n_edges == DebugHoldoffCycles) else begin
      errors++;
      $display("[FAIL] holdoff edges expected %0d actual %0d", DebugHoldoffCycles, n_edges);
    end

    // --------------------
    // file records
    // --------------------
    for (int r = 0; r < num_records; r++) begin
      if (rec_op[r] == "D") begin
        debug_req = rec_addr[r][0];
        debug_en  = rec_wdata[r][0];
        #2;
        assert (rec_rdata[r][0] == (debug_req & debug_en)) else begin
          errors++;
          $display("record %0s does not follow the debug gating rule", rec_name[r]);
        end
        assert (debug_req_o == rec_rdata[r][0]) else begin
          errors++;
          $display("[FAIL] %0s debug_req expected %0b actual %0b", rec_name[r],
                   rec_rdata[r][0], debug_req_o);
        end
        @(posedge clk_i);
        #1;
      end else begin
        model_access(rec_op[r] == "W", rec_addr[r], rec_be[r], rec_wdata[r], m_rdata, m_err);
        assert (m_err == rec_err[r] && (rec_op[r] == "W" || m_rdata == rec_rdata[r])) else begin
          errors++;
          $display("record %0s disagrees with the reference model", rec_name[r]);
        end
        issue(rec_name[r], rec_op[r] == "W", rec_addr[r], rec_be[r], rec_wdata[r],
              rec_rdata[r], rec_err[r]);
        idle_cycle();
      end
    end

    // back-to-back burst, banks taken in turn
    for (int k = 0; k < BurstLen; k++) begin
      lfsr_bits(8, rnd);
      burst_addr[k] = BankBase + (k % NumBanks) * BankStride + rnd[7:0] * 4;
      lfsr_bits(32, rnd);
      model_access(1'b1, burst_addr[k], 4'hf, rnd, m_rdata, m_err);
      issue("burst_wr", 1'b1, burst_addr[k], 4'hf, rnd, m_rdata, m_err);
    end
    for (int k = 0; k < BurstLen; k++) begin
      model_access(1'b0, burst_addr[k], 4'h0, '0, m_rdata, m_err);
      issue("burst_rd", 1'b0, burst_addr[k], 4'h0, '0, m_rdata, m_err);
    end

    // readback of every mapped word
    for (int w = 0; w < NumBanks*BankWords; w++) begin
      addr = BankBase + (w / BankWords) * BankStride + (w % BankWords) * 4;
      model_access(1'b0, addr, 4'h0, '0, m_rdata, m_err);
      issue("sweep_rd", 1'b0, addr, 4'h0, '0, m_rdata, m_err);
    end
    idle_cycle();

    $display("errors: %0d, records: %0d, cycles: %0d", errors, num_records, cycles);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/harness_top.sv */
// top of the memory-mapped harness, connects decoder, ram banks, response merger and debug hold-off
`default_nettype none
`timescale 1ns/10ps

module harness_top (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire mem_bus_pkg::mem_req_t req_i,
  output mem_bus_pkg::mem_rsp_t      rsp_o,
  input  wire                        debug_req_i,
  input  wire                        debug_en_i,
  output logic                       debug_req_o
);

  import soc_map_pkg::*;
  import mem_bus_pkg::*;

  // decoder to banks
  logic [NumBanks-1:0] bank_req;
  word_idx_t           word_idx;
  logic                bank_we;
  strb_t               bank_be;
  data_t               bank_wdata;

  // decoder to merger
  logic      acc;
  bank_idx_t sel;
  logic      unmapped;

  // banks to merger
  data_t bank_rdata [NumBanks];

  // --------------------
  // address decode
  // --------------------
  addr_decoder i_addr_decoder (
    .req_i      ( req_i      ),
    .bank_req_o ( bank_req   ),
    .word_idx_o ( word_idx   ),
    .we_o       ( bank_we    ),
    .be_o       ( bank_be    ),
    .wdata_o    ( bank_wdata ),
    .acc_o      ( acc        ),
    .sel_o      ( sel        ),
    .unmapped_o ( unmapped   )
  );

  // --------------------
  // ram banks
  // --------------------
  for (genvar i = 0; i < NumBanks; i++) begin : g_bank
    mem_bank i_mem_bank (
      .clk_i   ( clk_i         ),
      .rst_ni  ( rst_ni        ),
      .req_i   ( bank_req[i]   ),
      .we_i    ( bank_we       ),
      .be_i    ( bank_be       ),
      .idx_i   ( word_idx      ),
      .wdata_i ( bank_wdata    ),
      .rdata_o ( bank_rdata[i] )
    );
  end

  // --------------------
  // response path
  // --------------------
  rsp_merger i_rsp_merger (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .acc_i        ( acc        ),
    .sel_i        ( sel        ),
    .unmapped_i   ( unmapped   ),
    .bank_rdata_i ( bank_rdata ),
    .rsp_o        ( rsp_o      )
  );

  // --------------------
  // debug request
  // --------------------
  debug_holdoff i_debug_holdoff (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

/* logic/debug_holdoff.sv */
// blocks debug requests to the core for a fixed window after reset, then gates them by enable
`default_nettype none
`timescale 1ns/10ps

module debug_holdoff (
  input  wire  clk_i,
  input  wire  rst_ni,
  input  wire  debug_req_i,
  input  wire  debug_en_i,
  output logic debug_req_o
);

  import soc_map_pkg::*;

  localparam int CntWidth = $clog2(DebugHoldoffCycles + 1);

  typedef logic [CntWidth-1:0] cnt_t;

  cnt_t cnt_q;
  logic holdoff;

  assign holdoff = (cnt_q != '0);

  // --------------------
  // hold-off counter
  // --------------------

  // counts down once, then sticks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= cnt_t'(DebugHoldoffCycles);
    end else if (holdoff) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // enable gating, kept combinational
  assign debug_req_o = ~holdoff & debug_en_i & debug_req_i;

endmodule

`default_nettype wire

/* logic/rsp_merger.sv */
// response stage, picks the addressed bank's read data or returns an error for unmapped accesses
`default_nettype none
`timescale 1ns/10ps

module rsp_merger (
  input  wire                         clk_i,
  input  wire                         rst_ni,
  input  wire                         acc_i,
  input  wire soc_map_pkg::bank_idx_t sel_i,
  input  wire                         unmapped_i,
  input  wire mem_bus_pkg::data_t     bank_rdata_i [soc_map_pkg::NumBanks],
  output mem_bus_pkg::mem_rsp_t       rsp_o
);

  import soc_map_pkg::*;

  logic      acc_q;
  logic      unmapped_q;
  bank_idx_t sel_q;

  // --------------------
  // routing register
  // --------------------

  // same latency as the bank read port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q      <= 1'b0;
      unmapped_q <= 1'b0;
      sel_q      <= '0;
    end else begin
      acc_q      <= acc_i;
      unmapped_q <= unmapped_i;
      sel_q      <= sel_i;
    end
  end

  // --------------------
  // response select
  // --------------------

  // unmapped accesses act as an error slave
  always_comb begin
    rsp_o.valid = acc_q;
    rsp_o.err   = acc_q & unmapped_q;
    rsp_o.rdata = '0;
    if (acc_q && !unmapped_q) begin
      rsp_o.rdata = bank_rdata_i[sel_q];
    end
  end

  // the decoder flags unmapped only for an accepted access
  a_unmapped_has_acc: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    unmapped_i |-> acc_i
  ) else $error("unmapped flag raised without an access");

endmodule

`default_nettype wire

/* logic/mem_bank.sv */
// single ram region with byte-enabled writes and a registered read port, one per bank slot
`default_nettype none
`timescale 1ns/10ps

module mem_bank (
  input  wire                    clk_i,
  input  wire                    rst_ni,
  input  wire                    req_i,
  input  wire                    we_i,
  input  wire mem_bus_pkg::strb_t     be_i,
  input  wire mem_bus_pkg::word_idx_t idx_i,
  input  wire mem_bus_pkg::data_t     wdata_i,
  output mem_bus_pkg::data_t     rdata_o
);

  import soc_map_pkg::*;
  import mem_bus_pkg::*;

  data_t mem_q [BankWords];
  data_t wr_word;

  // ram starts cleared
  initial begin
    for (int w = 0; w < BankWords; w++) begin
      mem_q[w] = '0;
    end
  end

  // --------------------
  // byte merge
  // --------------------

  // old word with enabled bytes replaced
  always_comb begin
    wr_word = mem_q[idx_i];
    for (int b = 0; b < StrbWidth; b++) begin
      if (be_i[b]) begin
        wr_word[8*b +: 8] = wdata_i[8*b +: 8];
      end
    end
  end

  // --------------------
  // array and read port
  // --------------------

  // write-first, a write returns the merged word
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[idx_i] <= wr_word;
        rdata_o      <= wr_word;
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

  // a write with no byte enabled is a requester bug
  a_write_has_be: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_i && we_i) |-> (be_i != '0)
  ) else $error("write strobed with empty byte enables");

endmodule

`default_nettype wire

/* logic/addr_decoder.sv */
// combinational address decoder, steers each request to one ram bank or flags it unmapped
`default_nettype none
`timescale 1ns/10ps

module addr_decoder (
  input  wire  mem_bus_pkg::mem_req_t          req_i,
  // per-bank strobes
  output logic [soc_map_pkg::NumBanks-1:0]     bank_req_o,
  output mem_bus_pkg::word_idx_t               word_idx_o,
  output logic                                 we_o,
  output mem_bus_pkg::strb_t                   be_o,
  output mem_bus_pkg::data_t                   wdata_o,
  // routing info for the response path
  output logic                                 acc_o,
  output soc_map_pkg::bank_idx_t               sel_o,
  output logic                                 unmapped_o
);

  import soc_map_pkg::*;
  import mem_bus_pkg::*;

  logic [NumBanks-1:0] hit;
  bank_idx_t           sel;
  addr_t               offset;

  // base address of region i
  function automatic addr_t region_base(input int unsigned i);
    return addr_t'(BankBase + addr_t'(i) * BankStride);
  endfunction

  // --------------------
  // region match
  // --------------------
  always_comb begin
    hit    = '0;
    sel    = '0;
    offset = '0;
    for (int unsigned i = 0; i < NumBanks; i++) begin
      if ((req_i.addr >= region_base(i)) &&
          (req_i.addr < region_base(i) + addr_t'(BankBytes))) begin
        hit[i] = 1'b1;
        sel    = bank_idx_t'(i);
        offset = req_i.addr - region_base(i);
      end
    end
  end

  // --------------------
  // outputs
  // --------------------

  // strobe only the bank that was hit
  assign bank_req_o = req_i.req ? hit : '0;

  // byte offset to word index
  assign word_idx_o = offset[WordIdxWidth+1:2];

  // write payload goes to all banks, strobe picks one
  assign we_o    = req_i.we;
  assign be_o    = req_i.be;
  assign wdata_o = req_i.wdata;

  assign acc_o      = req_i.req;
  assign sel_o      = sel;
  assign unmapped_o = req_i.req & ~|hit;

  // regions in the map must not overlap
  a_bank_onehot: assert final ($onehot0(bank_req_o))
    else $error("more than one bank strobed for one address");

endmodule

`default_nettype wire

/* logic/mem_bus_pkg.sv */
// word bus types shared by the requester, the decoder, the banks and the response path
`default_nettype none

package mem_bus_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int AddrWidth    = 32;
  localparam int DataWidth    = 32;
  localparam int StrbWidth    = DataWidth / 8;
  // word offset inside one region
  localparam int WordIdxWidth = 8;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [StrbWidth-1:0]    strb_t;
  typedef logic [WordIdxWidth-1:0] word_idx_t;

  // --------------------
  // bus structs
  // --------------------

  // one-cycle request strobe, no grant
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    strb_t be;
    data_t wdata;
  } mem_req_t;

  // response, valid for a single cycle
  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

/* logic/soc_map_pkg.sv */
// address map and timing constants of the harness, imported by the decoder, banks and debug logic
`default_nettype none

package soc_map_pkg;

  // --------------------
  // ram regions
  // --------------------

  // number of ram regions behind the decoder
  localparam int NumBanks = 4;

  // region index as carried from decoder to merger
  typedef logic [$clog2(NumBanks)-1:0] bank_idx_t;

  // base of bank 0, the others follow at a fixed stride
  localparam logic [31:0] BankBase   = 32'h0000_1000;
  localparam logic [31:0] BankStride = 32'h0000_1000;

  // each region is smaller than the stride
  // the gap between regions decodes as unmapped
  localparam int unsigned BankBytes = 1024;

  // word count per region, 32-bit words
  localparam int unsigned BankWords = BankBytes / 4;

  // --------------------
  // debug
  // --------------------

  // hold-off window after reset
  // lets the core run its init code before it can be halted
  localparam int DebugHoldoffCycles = 500;

endpackage

`default_nettype wire
